//--- src/wormhole_pkg.sv
package wormhole_pkg;

  // physical flit width between the two ends of the link
  localparam int flit_width_c = 32;

  // destination coordinate, sits in the lowest bits of the first flit
  localparam int cord_width_c = 4;

  // number of flits that follow the first header flit
  localparam int len_width_c = 4;

  // full header word, wormhole fields plus protocol header
  localparam int hdr_width_c = 64;

  // number of flits that one header word occupies on the wire
  localparam int hdr_flits_c = hdr_width_c / flit_width_c;

  // ceiling of a over b, used to derive element counts from widths
  function automatic int cdiv(input int a, input int b);
    return (a + b - 1) / b;
  endfunction

  // the header as the client sees it, cord in the low bits so it leads on the wire
  typedef struct packed {
    logic [hdr_width_c-len_width_c-cord_width_c-1:0] pr_hdr;
    logic [len_width_c-1:0]                          len;
    logic [cord_width_c-1:0]                         cord;
  } wormhole_hdr_fields_s;

  // one header word, decoded either by field or as the flits that carry it
  typedef union packed {
    wormhole_hdr_fields_s                             fields;
    logic [hdr_flits_c-1:0][flit_width_c-1:0]         flits;
  } wormhole_hdr_u;

endpackage

//--- src/protocol_pkg.sv
package protocol_pkg;

  // protocol header carried behind the wormhole fields
  localparam int pr_hdr_width_c = 56;

  // one protocol data beat
  localparam int pr_data_width_c = 64;

  // field widths of the protocol header
  localparam int pr_opcode_width_c = 8;
  localparam int pr_tag_width_c = 8;
  localparam int pr_addr_width_c = 40;

  // the protocol header as the client fills it in
  // opcode sits on top so the address lands next to the wormhole length
  typedef struct packed {
    logic [pr_opcode_width_c-1:0] opcode;
    logic [pr_tag_width_c-1:0]    tag;
    logic [pr_addr_width_c-1:0]   addr;
  } pr_hdr_s;

endpackage

//--- src/stream_ctrl_if.sv
`timescale 1ns/100ps

// phase tracking between a stream block and its control
// the stream block reports flit moves, the control answers with the phase
interface stream_ctrl_if
  #(parameter int len_width_p = wormhole_pkg::len_width_c
  )
  ();

  // length field as it sits on the current link flit
  logic [len_width_p-1:0] len;
  // one pulse per flit that moves on the link
  logic                   accept;
  // phase of the next flit
  logic                   is_hdr;
  logic                   is_data;

  modport owner (output len, output accept, input is_hdr, input is_data);
  modport ctrl (input len, input accept, output is_hdr, output is_data);

endinterface

//--- src/wormhole_stream_control.sv
`timescale 1ns/100ps

// follows the flits of one link and tells header flits from data flits
module wormhole_stream_control
  #(parameter int len_width_p = 4
  , parameter int hdr_len_p = 2
  )
  (input logic          clk_i
  , input logic         reset_i
  , stream_ctrl_if.ctrl ctrl_io
  );

  // position of the next flit in its packet, zero means first header flit
  logic [len_width_p-1:0] cnt_r;
  // packet length, taken from the first header flit
  logic [len_width_p-1:0] len_r;
  // set once the header is through and data flits follow
  logic                   data_r;

  logic [len_width_p-1:0] cur_len;
  logic                   last_flit;
  logic                   hdr_done;

  // on the first flit the length is still on the wire and not yet stored
  assign cur_len = (cnt_r == '0) ? ctrl_io.len : len_r;

  // the length counts flits after the first, so the last one sits at index len
  assign last_flit = (cnt_r == cur_len);

  // this flit completes the header
  assign hdr_done = (cnt_r == len_width_p'(hdr_len_p - 1));

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          cnt_r  <= '0;
          data_r <= 1'b0;
        end
      else if (ctrl_io.accept)
        begin
          if (last_flit)
            begin
              // back to header phase for the next packet
              cnt_r  <= '0;
              data_r <= 1'b0;
            end
          else
            begin
              cnt_r <= cnt_r + 1'b1;
              // a packet that ends with its header never enters data phase
              if (hdr_done)
                data_r <= 1'b1;
            end
        end
    end

  // the length only matters once the first flit has gone by
  always_ff @(posedge clk_i)
    begin
      if (ctrl_io.accept && (cnt_r == '0))
        len_r <= ctrl_io.len;
    end

  // header phase follows the counter, data phase follows the flag
  assign ctrl_io.is_hdr  = (cnt_r < len_width_p'(hdr_len_p));
  assign ctrl_io.is_data = data_r;

  // counter and flag must always agree on exactly one phase
  // otherwise the owning block would steer a flit nowhere or twice
  a_one_phase: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot({ctrl_io.is_hdr, ctrl_io.is_data}));

endmodule

//--- src/serial_in_parallel_out.sv
`timescale 1ns/100ps

// gathers els_p narrow words into one wide word, first word in the low element
module serial_in_parallel_out
  #(parameter int width_p = 32
  , parameter int els_p = 2
  )
  (input logic                               clk_i
  , input logic                              reset_i
  , input logic [width_p-1:0]                data_i
  , input logic                              v_i
  , output logic                             ready_o
  , output logic [els_p-1:0][width_p-1:0]    data_o
  , output logic                             v_o
  , input logic                              yumi_i
  );

  localparam int cnt_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  // new words enter at the top and walk down to element zero
  logic [els_p-1:0][width_p-1:0] shift_r;
  // words taken so far for the word being built
  logic [cnt_width_lp-1:0]       cnt_r;
  // a complete word waits for the client
  logic                          full_r;

  logic accept;
  logic last_el;

  assign accept  = v_i & ready_o;
  assign last_el = (cnt_r == cnt_width_lp'(els_p - 1));

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          cnt_r  <= '0;
          full_r <= 1'b0;
        end
      else if (yumi_i)
        full_r <= 1'b0;
      else if (accept)
        begin
          if (last_el)
            begin
              cnt_r  <= '0;
              full_r <= 1'b1;
            end
          else
            cnt_r <= cnt_r + 1'b1;
        end
    end

  // after els_p shifts the first word has reached element zero
  always_ff @(posedge clk_i)
    begin
      if (accept)
        begin
          for (int i = 0; i < els_p - 1; i++)
            shift_r[i] <= shift_r[i+1];
          shift_r[els_p-1] <= data_i;
        end
    end

  // no new word comes in while a full one is still held
  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = shift_r;

  // the client may only take a word that is on offer
  a_yumi_on_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

//--- src/parallel_in_serial_out.sv
`timescale 1ns/100ps

// splits one wide word into els_p narrow words, lowest element first
module parallel_in_serial_out
  #(parameter int width_p = 32
  , parameter int els_p = 2
  )
  (input logic                               clk_i
  , input logic                              reset_i
  , input logic [els_p-1:0][width_p-1:0]     data_i
  , input logic                              valid_i
  , output logic                             ready_o
  , output logic [width_p-1:0]               data_o
  , output logic                             valid_o
  , input logic                              yumi_i
  );

  localparam int idx_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  // the word being sent out
  logic [els_p-1:0][width_p-1:0] data_r;
  // element currently on offer
  logic [idx_width_lp-1:0]       idx_r;
  // high from the word's arrival until its last element is taken
  logic                          busy_r;

  logic accept;
  logic last_el;

  assign accept  = valid_i & ready_o;
  assign last_el = (idx_r == idx_width_lp'(els_p - 1));

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          idx_r  <= '0;
          busy_r <= 1'b0;
        end
      else if (accept)
        begin
          idx_r  <= '0;
          busy_r <= 1'b1;
        end
      else if (yumi_i)
        begin
          if (last_el)
            begin
              // ready again on the next cycle
              idx_r  <= '0;
              busy_r <= 1'b0;
            end
          else
            idx_r <= idx_r + 1'b1;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (accept)
        data_r <= data_i;
    end

  assign ready_o = ~busy_r;
  assign valid_o = busy_r;
  assign data_o  = data_r[idx_r];

  // an element on offer holds until the consumer takes it
  a_hold_until_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && !yumi_i) |=> (valid_o && $stable(data_o)));

endmodule

//--- src/wormhole_stream_in.sv
`timescale 1ns/100ps

// sender side, serializes a header word and its data beats onto the flit wire
module wormhole_stream_in
  #(parameter int flit_width_p = 32
  , parameter int len_width_p = 4
  , parameter int cord_width_p = 4
  , parameter int hdr_width_p = 64
  , parameter int pr_data_width_p = 64
  )
  (input logic                          clk_i
  , input logic                         reset_i
  , input logic [hdr_width_p-1:0]       hdr_i
  , input logic                         hdr_v_i
  , output logic                        hdr_ready_and_o
  , input logic [pr_data_width_p-1:0]   data_i
  , input logic                         data_v_i
  , output logic                        data_ready_and_o
  , output logic [flit_width_p-1:0]     link_data_o
  , output logic                        link_v_o
  , input logic                         link_ready_and_i
  );

  localparam int hdr_len_lp = wormhole_pkg::cdiv(hdr_width_p, flit_width_p);
  localparam int data_len_lp = wormhole_pkg::cdiv(pr_data_width_p, flit_width_p);

  // the header seen as the flits that carry it
  wormhole_pkg::wormhole_hdr_u hdr_cast;

  logic [flit_width_p-1:0] hdr_flit;
  logic [flit_width_p-1:0] data_flit;
  logic                    hdr_flit_v;
  logic                    data_flit_v;
  logic                    link_accept;

  stream_ctrl_if #(.len_width_p(len_width_p)) ctrl_if ();

  assign hdr_cast = hdr_i;

  // header flits, the one with cord and len leaves first
  parallel_in_serial_out
    #(.width_p(flit_width_p)
    , .els_p  (hdr_len_lp)
    )
  hdr_piso
    (.clk_i  (clk_i)
    , .reset_i(reset_i)
    , .data_i (hdr_cast.flits)
    , .valid_i(hdr_v_i)
    , .ready_o(hdr_ready_and_o)
    , .data_o (hdr_flit)
    , .valid_o(hdr_flit_v)
    , .yumi_i (ctrl_if.is_hdr & link_accept)
    );

  // data flits, low half of each beat first
  parallel_in_serial_out
    #(.width_p(flit_width_p)
    , .els_p  (data_len_lp)
    )
  data_piso
    (.clk_i  (clk_i)
    , .reset_i(reset_i)
    , .data_i (data_i)
    , .valid_i(data_v_i)
    , .ready_o(data_ready_and_o)
    , .data_o (data_flit)
    , .valid_o(data_flit_v)
    , .yumi_i (ctrl_if.is_data & link_accept)
    );

  // the phase decides which buffer owns the wire
  // a data beat taken early simply waits until its header is out
  assign link_data_o = ctrl_if.is_hdr ? hdr_flit : data_flit;
  assign link_v_o    = ctrl_if.is_hdr ? hdr_flit_v : data_flit_v;
  assign link_accept = link_v_o & link_ready_and_i;

  // the length is only looked at on the first header flit
  assign ctrl_if.len    = link_data_o[cord_width_p+:len_width_p];
  assign ctrl_if.accept = link_accept;

  wormhole_stream_control
    #(.len_width_p(len_width_p)
    , .hdr_len_p  (hdr_len_lp)
    )
  stream_control
    (.clk_i  (clk_i)
    , .reset_i(reset_i)
    , .ctrl_io(ctrl_if.ctrl)
    );

  // the flit view of the header is fixed by the link format
  if ($bits(wormhole_pkg::wormhole_hdr_u) != hdr_width_p
      || wormhole_pkg::flit_width_c != flit_width_p)
    begin : g_hdr_view_check
      $fatal(1, "header view needs %0d-bit headers on %0d-bit flits",
             $bits(wormhole_pkg::wormhole_hdr_u), wormhole_pkg::flit_width_c);
    end

  if (pr_data_width_p % flit_width_p != 0)
    begin : g_data_width_check
      $fatal(1, "data width %0d is not a multiple of flit width %0d",
             pr_data_width_p, flit_width_p);
    end

endmodule

//--- src/wormhole_stream_out.sv
`timescale 1ns/100ps

// receiver side, splits the flit stream into a header word and data beats
// only one item is gathered at a time, the client drains each with yumi
module wormhole_stream_out
  #(parameter int flit_width_p = 32
  , parameter int len_width_p = 4
  , parameter int cord_width_p = 4
  , parameter int hdr_width_p = 64
  , parameter int pr_data_width_p = 64
  )
  (input logic                          clk_i
  , input logic                         reset_i
  , input logic [flit_width_p-1:0]      link_data_i
  , input logic                         link_v_i
  , output logic                        link_ready_and_o
  , output logic [hdr_width_p-1:0]      hdr_o
  , output logic                        hdr_v_o
  , input logic                         hdr_yumi_i
  , output logic [pr_data_width_p-1:0]  data_o
  , output logic                        data_v_o
  , input logic                         data_yumi_i
  );

  localparam int hdr_len_lp = wormhole_pkg::cdiv(hdr_width_p, flit_width_p);
  localparam int data_len_lp = wormhole_pkg::cdiv(pr_data_width_p, flit_width_p);

  logic [hdr_len_lp-1:0][flit_width_p-1:0]  hdr_lo;
  logic [data_len_lp-1:0][flit_width_p-1:0] data_lo;
  logic                                     hdr_ready_lo;
  logic                                     data_ready_lo;

  stream_ctrl_if #(.len_width_p(len_width_p)) ctrl_if ();

  // header flits collect here until the whole word is there
  serial_in_parallel_out
    #(.width_p(flit_width_p)
    , .els_p  (hdr_len_lp)
    )
  hdr_sipo
    (.clk_i  (clk_i)
    , .reset_i(reset_i)
    , .data_i (link_data_i)
    , .v_i    (ctrl_if.is_hdr & link_v_i)
    , .ready_o(hdr_ready_lo)
    , .data_o (hdr_lo)
    , .v_o    (hdr_v_o)
    , .yumi_i (hdr_yumi_i)
    );

  // data flits collect here one beat at a time
  serial_in_parallel_out
    #(.width_p(flit_width_p)
    , .els_p  (data_len_lp)
    )
  data_sipo
    (.clk_i  (clk_i)
    , .reset_i(reset_i)
    , .data_i (link_data_i)
    , .v_i    (ctrl_if.is_data & link_v_i)
    , .ready_o(data_ready_lo)
    , .data_o (data_lo)
    , .v_o    (data_v_o)
    , .yumi_i (data_yumi_i)
    );

  assign hdr_o  = hdr_lo;
  assign data_o = data_lo;

  // a full buffer in the current phase stalls the whole link
  assign link_ready_and_o = ctrl_if.is_hdr ? hdr_ready_lo : data_ready_lo;

  assign ctrl_if.len    = link_data_i[cord_width_p+:len_width_p];
  assign ctrl_if.accept = link_v_i & link_ready_and_o;

  wormhole_stream_control
    #(.len_width_p(len_width_p)
    , .hdr_len_p  (hdr_len_lp)
    )
  stream_control
    (.clk_i  (clk_i)
    , .reset_i(reset_i)
    , .ctrl_io(ctrl_if.ctrl)
    );

  if (hdr_width_p % flit_width_p != 0)
    begin : g_hdr_width_check
      $fatal(1, "header width %0d is not a multiple of flit width %0d",
             hdr_width_p, flit_width_p);
    end

  if (pr_data_width_p % flit_width_p != 0)
    begin : g_data_width_check
      $fatal(1, "data width %0d is not a multiple of flit width %0d",
             pr_data_width_p, flit_width_p);
    end

endmodule

//--- src/wormhole_stream_link.sv
`timescale 1ns/100ps

// sender and receiver joined over one flit wire
module wormhole_stream_link
  #(parameter int flit_width_p = wormhole_pkg::flit_width_c
  , parameter int cord_width_p = wormhole_pkg::cord_width_c
  , parameter int len_width_p = wormhole_pkg::len_width_c
  , parameter int pr_hdr_width_p = protocol_pkg::pr_hdr_width_c
  , parameter int pr_data_width_p = protocol_pkg::pr_data_width_c
  , localparam int hdr_width_lp = cord_width_p + len_width_p + pr_hdr_width_p
  )
  (input logic                          clk_i
  , input logic                         reset_i
  , input logic [hdr_width_lp-1:0]      hdr_i
  , input logic                         hdr_v_i
  , output logic                        hdr_ready_and_o
  , input logic [pr_data_width_p-1:0]   data_i
  , input logic                         data_v_i
  , output logic                        data_ready_and_o
  , output logic [hdr_width_lp-1:0]     hdr_o
  , output logic                        hdr_v_o
  , input logic                         hdr_yumi_i
  , output logic [pr_data_width_p-1:0]  data_o
  , output logic                        data_v_o
  , input logic                         data_yumi_i
  );

  // the flit wire between the two ends
  logic [flit_width_p-1:0] flit;
  logic                    flit_v;
  logic                    flit_ready_and;

  wormhole_stream_in
    #(.flit_width_p   (flit_width_p)
    , .len_width_p    (len_width_p)
    , .cord_width_p   (cord_width_p)
    , .hdr_width_p    (hdr_width_lp)
    , .pr_data_width_p(pr_data_width_p)
    )
  stream_in
    (.clk_i           (clk_i)
    , .reset_i         (reset_i)
    , .hdr_i           (hdr_i)
    , .hdr_v_i         (hdr_v_i)
    , .hdr_ready_and_o (hdr_ready_and_o)
    , .data_i          (data_i)
    , .data_v_i        (data_v_i)
    , .data_ready_and_o(data_ready_and_o)
    , .link_data_o     (flit)
    , .link_v_o        (flit_v)
    , .link_ready_and_i(flit_ready_and)
    );

  wormhole_stream_out
    #(.flit_width_p   (flit_width_p)
    , .len_width_p    (len_width_p)
    , .cord_width_p   (cord_width_p)
    , .hdr_width_p    (hdr_width_lp)
    , .pr_data_width_p(pr_data_width_p)
    )
  stream_out
    (.clk_i           (clk_i)
    , .reset_i         (reset_i)
    , .link_data_i     (flit)
    , .link_v_i        (flit_v)
    , .link_ready_and_o(flit_ready_and)
    , .hdr_o           (hdr_o)
    , .hdr_v_o         (hdr_v_o)
    , .hdr_yumi_i      (hdr_yumi_i)
    , .data_o          (data_o)
    , .data_v_o        (data_v_o)
    , .data_yumi_i     (data_yumi_i)
    );

endmodule

//--- dv/stream_checker.sv
`timescale 1ns/100ps

// watches the receiver side of the link and compares every taken item
// with the queues that the stimulus fills in
module stream_checker
  #(parameter int hdr_width_p = 64
  , parameter int data_width_p = 64
  )
  (input logic                      clk_i
  , input logic                     reset_i
  , input logic                     hdr_ready_and_i
  , input logic                     data_ready_and_i
  , input logic [hdr_width_p-1:0]   hdr_i
  , input logic                     hdr_v_i
  , input logic                     hdr_yumi_i
  , input logic [data_width_p-1:0]  data_i
  , input logic                     data_v_i
  , input logic                     data_yumi_i
  );

  // expected headers and beats in send order, each beat tagged with its packet
  logic [hdr_width_p-1:0]  hdr_q [$];
  logic [data_width_p-1:0] data_q [$];
  int                      data_pkt_q [$];

  int err_cnt = 0;
  int hdr_cnt = 0;
  int beat_cnt = 0;

  logic                    reset_q = 1'b1;
  logic                    hdr_hold_r = 1'b0;
  logic                    data_hold_r = 1'b0;
  logic [hdr_width_p-1:0]  hdr_prev_r;
  logic [data_width_p-1:0] data_prev_r;

  always @(posedge clk_i)
  begin
    logic [hdr_width_p-1:0]  exp_hdr;
    logic [data_width_p-1:0] exp_data;
    int                      exp_pkt;
    if (!reset_i)
    begin
      // first edge out of reset, nothing on offer and both inputs open
      if (reset_q && (hdr_v_i || data_v_i || !hdr_ready_and_i || !data_ready_and_i))
      begin
        $display("FAIL after reset: hdr_v_o=%h data_v_o=%h hdr_ready_and_o=%h data_ready_and_o=%h",
                 hdr_v_i, data_v_i, hdr_ready_and_i, data_ready_and_i);
        err_cnt++;
      end
      // an item not yet taken must stay on offer unchanged
      if (hdr_hold_r && !hdr_v_i)
      begin
        $display("hdr_v_o dropped before the header was taken");
        err_cnt++;
      end
      else if (hdr_hold_r && hdr_i !== hdr_prev_r)
      begin
        $display("FAIL hdr_o changed while held: was %h now %h", hdr_prev_r, hdr_i);
        err_cnt++;
      end
      if (data_hold_r && !data_v_i)
      begin
        $display("data_v_o dropped before the beat was taken");
        err_cnt++;
      end
      else if (data_hold_r && data_i !== data_prev_r)
      begin
        $display("FAIL data_o changed while held: was %h now %h", data_prev_r, data_i);
        err_cnt++;
      end
      if (hdr_yumi_i)
      begin
        if (hdr_q.size() == 0)
        begin
          $display("a header was delivered while no header was expected");
          err_cnt++;
        end
        else
        begin
          exp_hdr = hdr_q.pop_front();
          if (hdr_i !== exp_hdr)
          begin
            $display("FAIL hdr_o: got %h expected %h", hdr_i, exp_hdr);
            err_cnt++;
          end
          hdr_cnt++;
        end
      end
      if (data_yumi_i)
      begin
        if (data_q.size() == 0)
        begin
          $display("a data beat was delivered while no beat was expected");
          err_cnt++;
        end
        else
        begin
          exp_data = data_q.pop_front();
          exp_pkt = data_pkt_q.pop_front();
          if (data_i !== exp_data)
          begin
            $display("FAIL data_o: got %h expected %h", data_i, exp_data);
            err_cnt++;
          end
          // the header of the packet before must be gone before this beat can form
          if (exp_pkt > hdr_cnt)
          begin
            $display("a beat of packet %0d came out while header %0d was still held",
                     exp_pkt, exp_pkt - 1);
            err_cnt++;
          end
          beat_cnt++;
        end
      end
    end
    hdr_hold_r = !reset_i && hdr_v_i && !hdr_yumi_i;
    data_hold_r = !reset_i && data_v_i && !data_yumi_i;
    hdr_prev_r = hdr_i;
    data_prev_r = data_i;
    reset_q = reset_i;
  end

  // end of run, everything sent must be out and the outputs quiet
  function automatic void check_drained();
    if (hdr_q.size() != 0 || data_q.size() != 0)
    begin
      $display("%0d headers and %0d beats were sent but never delivered",
               hdr_q.size(), data_q.size());
      err_cnt++;
    end
    if (hdr_v_i || data_v_i)
    begin
      $display("an output valid is still high with nothing left to deliver");
      err_cnt++;
    end
  endfunction

endmodule

//--- dv/tb_wormhole_stream.sv
`timescale 1ns/100ps

module tb_wormhole_stream;

  localparam int num_pkts_lp = 200;
  localparam int max_beats_lp = 5;
  localparam int reset_cycles_lp = 16;
  // two header flits and two flits per beat
  localparam int max_flits_lp = 2 + 2 * max_beats_lp;
  localparam int cycle_limit_lp = num_pkts_lp * max_flits_lp * 8 + reset_cycles_lp;
  localparam int hdr_width_lp = wormhole_pkg::hdr_width_c;
  localparam int data_width_lp = protocol_pkg::pr_data_width_c;

  // empty packets back to back and next to short ones before the random run
  localparam int first_counts_lp [6] = '{0, 0, 1, 0, 2, 0};

  logic                     clk_i;
  logic                     reset_i;
  logic [hdr_width_lp-1:0]  hdr_i;
  logic                     hdr_v_i;
  logic                     hdr_ready_and_o;
  logic [data_width_lp-1:0] data_i;
  logic                     data_v_i;
  logic                     data_ready_and_o;
  logic [hdr_width_lp-1:0]  hdr_o;
  logic                     hdr_v_o;
  logic                     hdr_yumi_i;
  logic [data_width_lp-1:0] data_o;
  logic                     data_v_o;
  logic                     data_yumi_i;

  logic [31:0] lfsr_r;
  logic        slow_yumi;
  int          cycle_cnt = 0;

  always #4 clk_i = ~clk_i;

  wormhole_stream_link
    #(.flit_width_p   (wormhole_pkg::flit_width_c)
    , .cord_width_p   (wormhole_pkg::cord_width_c)
    , .len_width_p    (wormhole_pkg::len_width_c)
    , .pr_hdr_width_p (protocol_pkg::pr_hdr_width_c)
    , .pr_data_width_p(data_width_lp)
    )
  dut_i
    (.clk_i(clk_i), .reset_i(reset_i)
    , .hdr_i(hdr_i), .hdr_v_i(hdr_v_i), .hdr_ready_and_o(hdr_ready_and_o)
    , .data_i(data_i), .data_v_i(data_v_i), .data_ready_and_o(data_ready_and_o)
    , .hdr_o(hdr_o), .hdr_v_o(hdr_v_o), .hdr_yumi_i(hdr_yumi_i)
    , .data_o(data_o), .data_v_o(data_v_o), .data_yumi_i(data_yumi_i)
    );

  stream_checker
    #(.hdr_width_p(hdr_width_lp)
    , .data_width_p(data_width_lp)
    )
  checker_i
    (.clk_i(clk_i), .reset_i(reset_i)
    , .hdr_ready_and_i(hdr_ready_and_o), .data_ready_and_i(data_ready_and_o)
    , .hdr_i(hdr_o), .hdr_v_i(hdr_v_o), .hdr_yumi_i(hdr_yumi_i)
    , .data_i(data_o), .data_v_i(data_v_o), .data_yumi_i(data_yumi_i)
    );

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_r = lfsr_step(lfsr_r);
      v = {v[62:0], lfsr_r[0]};
    end
    return v;
  endfunction

  function automatic logic yumi_chance();
    if (slow_yumi)
      return take_bits(3) == 0;
    return take_bits(2) != 0;
  endfunction

  // expected receiver output, header packed with cord lowest and len 1 + 2N above it
  function automatic void expect_packet(input int pkt, input logic [3:0] cord,
                                        input protocol_pkg::pr_hdr_s pr,
                                        input logic [data_width_lp-1:0] beats [$]);
    logic [hdr_width_lp-1:0] exp_hdr;
    exp_hdr = {pr.opcode, pr.tag, pr.addr, 4'(1 + 2 * beats.size()), cord};
    checker_i.hdr_q.push_back(exp_hdr);
    foreach (beats[i])
    begin
      checker_i.data_q.push_back(beats[i]);
      checker_i.data_pkt_q.push_back(pkt);
    end
  endfunction

  // one cycle, yumi only ever answers a valid already standing
  task automatic tick();
    @(negedge clk_i);
    hdr_yumi_i = yumi_chance() && hdr_v_o;
    data_yumi_i = yumi_chance() && data_v_o;
  endtask

  task automatic idle_gap();
    int gap;
    gap = (take_bits(2) == 2'b11) ? int'(take_bits(2)) + 1 : 0;
    repeat (gap) tick();
  endtask

  // ready is a register, so the level seen now holds through the next rising edge
  task automatic send_hdr(input logic [hdr_width_lp-1:0] h);
    idle_gap();
    hdr_i = h;
    hdr_v_i = 1'b1;
    while (!hdr_ready_and_o)
      tick();
    tick();
    hdr_v_i = 1'b0;
  endtask

  task automatic send_data(input logic [data_width_lp-1:0] d);
    idle_gap();
    data_i = d;
    data_v_i = 1'b1;
    while (!data_ready_and_o)
      tick();
    tick();
    data_v_i = 1'b0;
  endtask

  task automatic send_packet(input int pkt, input int n_beats);
    wormhole_pkg::wormhole_hdr_u hdr;
    protocol_pkg::pr_hdr_s       pr;
    logic [3:0]                  cord;
    logic [data_width_lp-1:0]    beats [$];
    pr.opcode = 8'(take_bits(8));
    pr.tag = 8'(take_bits(8));
    pr.addr = 40'(take_bits(40));
    cord = 4'(take_bits(4));
    for (int i = 0; i < n_beats; i++)
      beats.push_back(take_bits(64));
    hdr.fields.cord = cord;
    hdr.fields.len = 4'(1 + 2 * n_beats);
    hdr.fields.pr_hdr = pr;
    expect_packet(pkt, cord, pr, beats);
    send_hdr(hdr);
    foreach (beats[i])
      send_data(beats[i]);
  endtask

  task automatic print_counts();
    $display("headers %0d, beats %0d, errors %0d",
             checker_i.hdr_cnt, checker_i.beat_cnt, checker_i.err_cnt);
  endtask

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit_lp)
    begin
      $display("timeout after %0d cycles with %0d headers and %0d beats still expected",
               cycle_cnt, checker_i.hdr_q.size(), checker_i.data_q.size());
      print_counts();
      $display("Verification failed");
      $finish;
    end
  end

  initial
  begin
    int n_beats;
    clk_i = 1'b0;
    reset_i = 1'b1;
    hdr_i = '0;
    hdr_v_i = 1'b0;
    data_i = '0;
    data_v_i = 1'b0;
    hdr_yumi_i = 1'b0;
    data_yumi_i = 1'b0;
    lfsr_r = 32'h202c_fe1f;
    slow_yumi = 1'b0;
    repeat (reset_cycles_lp) @(negedge clk_i);
    reset_i = 1'b0;
    for (int p = 0; p < num_pkts_lp; p++)
    begin
      if (p < 6)
        n_beats = first_counts_lp[p];
      else
        n_beats = int'(take_bits(3)) % (max_beats_lp + 1);
      // a stretch of heavy withholding backs the whole link up
      slow_yumi = (p >= 100) && (p < 140);
      send_packet(p, n_beats);
    end
    slow_yumi = 1'b0;
    while (checker_i.hdr_q.size() != 0 || checker_i.data_q.size() != 0)
      tick();
    // a quiet tail lets a stray valid show up
    repeat (20) tick();
    checker_i.check_drained();
    print_counts();
    if (checker_i.err_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- vlog.f
src/wormhole_pkg.sv
src/protocol_pkg.sv
src/stream_ctrl_if.sv
src/wormhole_stream_control.sv
src/serial_in_parallel_out.sv
src/parallel_in_serial_out.sv
src/wormhole_stream_in.sv
src/wormhole_stream_out.sv
src/wormhole_stream_link.sv
dv/stream_checker.sv
dv/tb_wormhole_stream.sv

//--- Bender.yml
package:
  name: wormhole_stream

sources:
  - src/wormhole_pkg.sv
  - src/protocol_pkg.sv
  - src/stream_ctrl_if.sv
  - src/wormhole_stream_control.sv
  - src/serial_in_parallel_out.sv
  - src/parallel_in_serial_out.sv
  - src/wormhole_stream_in.sv
  - src/wormhole_stream_out.sv
  - src/wormhole_stream_link.sv
  - target: test
    files:
      - dv/stream_checker.sv
      - dv/tb_wormhole_stream.sv
